// File: Bender.yml
package:
  name: pipeline_regs

sources:
  - files:
      - pipeRegPkg.sv
      - fetchStageReg.sv
      - decodeStageReg.sv
      - executeStageReg.sv
      - memAccessStageReg.sv
      - memResponseStageReg.sv
      - writebackStageReg.sv
      - pipelineRegs.sv
  - target: test
    files:
      - pipelineRegsTb.sv

// File: decodeStageReg.sv
`timescale 1ns/100ps

module decodeStageReg (
	input logic clk,
	input logic rst,
	input logic wr,
	input logic flush,
	input logic [pipeRegPkg::addrWidth-1:0] pc,
	input logic exception,
	input logic [pipeRegPkg::excCodeWidth-1:0] excCode,
	input pipeRegPkg::instrWord instr,
	output logic [pipeRegPkg::addrWidth-1:0] idPc,
	output logic idException,
	output logic [pipeRegPkg::excCodeWidth-1:0] idExcCode,
	output logic [5:0] opcode,
	output logic [pipeRegPkg::regAddrWidth-1:0] rs,
	output logic [pipeRegPkg::regAddrWidth-1:0] rt,
	output logic [pipeRegPkg::regAddrWidth-1:0] rd,
	output logic [4:0] shamt,
	output logic [5:0] funct,
	output logic [15:0] imm16,
	output logic [25:0] target26
);

	pipeRegPkg::instrWord instrReg;

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			idPc <= '0;
			idException <= 1'b0;
			idExcCode <= '0;
			instrReg <= '0;
		end else if (wr) begin
			idPc <= pc;
			idException <= exception;
			idExcCode <= excCode;
			instrReg <= instr;
		end
	end

	// the register fields come from the R view
	assign opcode = instrReg.rType.opcode;
	assign rs = instrReg.rType.rs;
	assign rt = instrReg.rType.rt;
	assign rd = instrReg.rType.rd;
	assign shamt = instrReg.rType.shamt;
	assign funct = instrReg.rType.funct;

	// immediate and jump target overlay the low bits of the same word
	assign imm16 = instrReg.iType.imm16;
	assign target26 = instrReg.jType.target26;

endmodule

// File: executeStageReg.sv
`timescale 1ns/100ps

module executeStageReg (
	input logic clk,
	input logic rst,
	input logic wr,
	input logic flush,
	input logic [pipeRegPkg::addrWidth-1:0] idPc,
	input logic idException,
	input logic [pipeRegPkg::excCodeWidth-1:0] idExcCode,
	input logic [pipeRegPkg::regAddrWidth-1:0] rt,
	input logic [pipeRegPkg::regAddrWidth-1:0] rd,
	input logic regDstRd,
	input logic regWrite,
	input logic memRead,
	input logic memWrite,
	output logic [pipeRegPkg::addrWidth-1:0] exPc,
	output logic exException,
	output logic [pipeRegPkg::excCodeWidth-1:0] exExcCode,
	output logic [pipeRegPkg::regAddrWidth-1:0] exDest,
	output logic exRegWrite,
	output logic exMemRead,
	output logic exMemWrite,
	output logic stall
);

	logic [pipeRegPkg::regAddrWidth-1:0] destSel;

	// R-type writes rd, immediate forms write rt
	assign destSel = regDstRd ? rd : rt;

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			exPc <= '0;
			exException <= 1'b0;
			exExcCode <= '0;
			exDest <= '0;
			exRegWrite <= 1'b0;
			exMemRead <= 1'b0;
			exMemWrite <= 1'b0;
			stall <= 1'b0;
		end else if (wr) begin
			exPc <= idPc;
			exException <= idException;
			exExcCode <= idExcCode;
			exDest <= destSel;
			exRegWrite <= regWrite;
			exMemRead <= memRead;
			exMemWrite <= memWrite;
			stall <= 1'b0;
		end else begin
			stall <= 1'b1;
		end
	end

	// the decoder never issues a load and a store for one instruction
	loadStoreExclusive: assert property (@(posedge clk) disable iff (rst)
		!(exMemRead && exMemWrite))
		else $error("execute stage holds both memRead and memWrite");

endmodule

// File: fetchStageReg.sv
`timescale 1ns/100ps

module fetchStageReg (
	input logic clk,
	input logic rst,
	input logic wr,
	input logic flush,
	input logic [pipeRegPkg::addrWidth-1:0] nextPc,
	input logic fetchException,
	input logic [pipeRegPkg::excCodeWidth-1:0] fetchExcCode,
	output logic [pipeRegPkg::addrWidth-1:0] pc,
	output logic exception,
	output logic [pipeRegPkg::excCodeWidth-1:0] excCode,
	output logic stall
);

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			pc <= pipeRegPkg::fetchResetPc;
			exception <= 1'b0;
			excCode <= '0;
			stall <= 1'b0;
		end else if (wr) begin
			pc <= nextPc;
			exception <= fetchException;
			excCode <= fetchExcCode;
			stall <= 1'b0;
		end else begin
			// hazard unit is holding the front end
			stall <= 1'b1;
		end
	end

	// a flush from the hazard unit must release the front end on the next cycle
	stallReleasedByFlush: assert property (@(posedge clk) flush |=> !stall)
		else $error("fetch stall still set after flush");

endmodule

// File: files.f
pipeRegPkg.sv
fetchStageReg.sv
decodeStageReg.sv
executeStageReg.sv
memAccessStageReg.sv
memResponseStageReg.sv
writebackStageReg.sv
pipelineRegs.sv
pipelineRegsTb.sv

// File: memAccessStageReg.sv
`timescale 1ns/100ps

module memAccessStageReg (
	input logic clk,
	input logic rst,
	input logic wr,
	input logic flush,
	input logic [pipeRegPkg::addrWidth-1:0] exPc,
	input logic exException,
	input logic [pipeRegPkg::excCodeWidth-1:0] exExcCode,
	input logic [pipeRegPkg::regAddrWidth-1:0] exDest,
	input logic exRegWrite,
	input logic exMemRead,
	input logic [pipeRegPkg::dataWidth-1:0] aluResult,
	input logic overflow,
	output logic [pipeRegPkg::addrWidth-1:0] m1Pc,
	output logic m1Exception,
	output logic [pipeRegPkg::excCodeWidth-1:0] m1ExcCode,
	output logic [pipeRegPkg::regAddrWidth-1:0] m1Dest,
	output logic m1RegWrite,
	output logic m1MemRead,
	output logic [pipeRegPkg::dataWidth-1:0] m1Result
);

	logic takeOverflow;

	// an exception raised earlier in the pipe keeps priority over overflow
	assign takeOverflow = overflow && !exException;

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			m1Pc <= '0;
			m1Exception <= 1'b0;
			m1ExcCode <= '0;
			m1Dest <= '0;
			m1RegWrite <= 1'b0;
			m1MemRead <= 1'b0;
			m1Result <= '0;
		end else if (wr) begin
			m1Pc <= exPc;
			m1Exception <= exException || takeOverflow;
			m1ExcCode <= takeOverflow ? pipeRegPkg::excOverflow : exExcCode;
			m1Dest <= exDest;
			m1RegWrite <= exRegWrite;
			m1MemRead <= exMemRead;
			m1Result <= aluResult;
		end
	end

	// a code only travels with a raised flag, from fetch or from here
	codeImpliesException: assert property (@(posedge clk) disable iff (rst)
		(m1ExcCode != '0) |-> m1Exception)
		else $error("exception code %0d carried without exception flag", m1ExcCode);

endmodule

// File: memResponseStageReg.sv
`timescale 1ns/100ps

module memResponseStageReg (
	input logic clk,
	input logic rst,
	input logic wr,
	input logic flush,
	input logic [pipeRegPkg::addrWidth-1:0] m1Pc,
	input logic m1Exception,
	input logic [pipeRegPkg::excCodeWidth-1:0] m1ExcCode,
	input logic [pipeRegPkg::regAddrWidth-1:0] m1Dest,
	input logic m1RegWrite,
	input logic m1MemRead,
	input logic [pipeRegPkg::dataWidth-1:0] m1Result,
	output logic [pipeRegPkg::addrWidth-1:0] m2Pc,
	output logic m2Exception,
	output logic [pipeRegPkg::excCodeWidth-1:0] m2ExcCode,
	output logic [pipeRegPkg::regAddrWidth-1:0] m2Dest,
	output logic m2RegWrite,
	output logic m2MemRead,
	output logic [pipeRegPkg::dataWidth-1:0] m2Result
);

	// request state waits here while the data memory returns the load
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			m2Pc <= '0;
			m2Exception <= 1'b0;
			m2ExcCode <= '0;
			m2Dest <= '0;
			m2RegWrite <= 1'b0;
			m2MemRead <= 1'b0;
			m2Result <= '0;
		end else if (wr) begin
			m2Pc <= m1Pc;
			m2Exception <= m1Exception;
			m2ExcCode <= m1ExcCode;
			m2Dest <= m1Dest;
			m2RegWrite <= m1RegWrite;
			m2MemRead <= m1MemRead;
			m2Result <= m1Result;
		end
	end

endmodule

// File: pipeRegPkg.sv
package pipeRegPkg;

	localparam int addrWidth = 32;
	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int excCodeWidth = 5;

	// one word ahead of the boot vector, so the first fetch lands on it
	localparam logic [addrWidth-1:0] fetchResetPc = 32'hbfbf_fffc;

	localparam logic [excCodeWidth-1:0] excOverflow = 5'd12;

	typedef struct packed {
		logic [5:0] opcode;
		logic [regAddrWidth-1:0] rs;
		logic [regAddrWidth-1:0] rt;
		logic [regAddrWidth-1:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rTypeFields;

	typedef struct packed {
		logic [5:0] opcode;
		logic [regAddrWidth-1:0] rs;
		logic [regAddrWidth-1:0] rt;
		logic [15:0] imm16;
	} iTypeFields;

	typedef struct packed {
		logic [5:0] opcode;
		logic [25:0] target26;
	} jTypeFields;

	// the same fetched word seen as register fields, immediate or jump target
	typedef union packed {
		rTypeFields rType;
		iTypeFields iType;
		jTypeFields jType;
	} instrWord;

endpackage

// File: pipelineRegs.sv
`timescale 1ns/100ps

module pipelineRegs (
	input logic clk,
	input logic rst,
	input logic ifWr,
	input logic ifFlush,
	input logic idWr,
	input logic idFlush,
	input logic exWr,
	input logic exFlush,
	input logic mem1Wr,
	input logic mem1Flush,
	input logic mem2Wr,
	input logic mem2Flush,
	input logic wbWr,
	input logic wbFlush,
	input logic [pipeRegPkg::addrWidth-1:0] nextPc,
	input logic fetchException,
	input logic [pipeRegPkg::excCodeWidth-1:0] fetchExcCode,
	input pipeRegPkg::instrWord instr,
	input logic regDstRd,
	input logic regWrite,
	input logic memRead,
	input logic memWrite,
	input logic [pipeRegPkg::dataWidth-1:0] aluResult,
	input logic overflow,
	input logic [pipeRegPkg::dataWidth-1:0] loadData,
	output logic [pipeRegPkg::addrWidth-1:0] ifPc,
	output logic ifStall,
	output logic [5:0] opcode,
	output logic [pipeRegPkg::regAddrWidth-1:0] rs,
	output logic [pipeRegPkg::regAddrWidth-1:0] rt,
	output logic [15:0] imm16,
	output logic [25:0] target26,
	output logic [pipeRegPkg::regAddrWidth-1:0] exDest,
	output logic exStall,
	output logic [pipeRegPkg::addrWidth-1:0] wbPc,
	output logic wbException,
	output logic [pipeRegPkg::excCodeWidth-1:0] wbExcCode,
	output logic [pipeRegPkg::regAddrWidth-1:0] wbDest,
	output logic wbRegWrite,
	output logic [pipeRegPkg::dataWidth-1:0] wbResult
);

	logic ifException;
	logic [pipeRegPkg::excCodeWidth-1:0] ifExcCode;

	logic [pipeRegPkg::addrWidth-1:0] idPc;
	logic idException;
	logic [pipeRegPkg::excCodeWidth-1:0] idExcCode;
	logic [pipeRegPkg::regAddrWidth-1:0] idRd;

	logic [pipeRegPkg::addrWidth-1:0] exPc;
	logic exException;
	logic [pipeRegPkg::excCodeWidth-1:0] exExcCode;
	logic exRegWrite;
	logic exMemRead;

	logic [pipeRegPkg::addrWidth-1:0] m1Pc;
	logic m1Exception;
	logic [pipeRegPkg::excCodeWidth-1:0] m1ExcCode;
	logic [pipeRegPkg::regAddrWidth-1:0] m1Dest;
	logic m1RegWrite;
	logic m1MemRead;
	logic [pipeRegPkg::dataWidth-1:0] m1Result;

	logic [pipeRegPkg::addrWidth-1:0] m2Pc;
	logic m2Exception;
	logic [pipeRegPkg::excCodeWidth-1:0] m2ExcCode;
	logic [pipeRegPkg::regAddrWidth-1:0] m2Dest;
	logic m2RegWrite;
	logic m2MemRead;
	logic [pipeRegPkg::dataWidth-1:0] m2Result;

	fetchStageReg fetch_i (
		.clk(clk), .rst(rst), .wr(ifWr), .flush(ifFlush),
		.nextPc(nextPc), .fetchException(fetchException), .fetchExcCode(fetchExcCode),
		.pc(ifPc), .exception(ifException), .excCode(ifExcCode), .stall(ifStall)
	);

	// shamt and funct go to the ALU decoder, which lives outside this block
	decodeStageReg decode_i (
		.clk(clk), .rst(rst), .wr(idWr), .flush(idFlush),
		.pc(ifPc), .exception(ifException), .excCode(ifExcCode), .instr(instr),
		.idPc(idPc), .idException(idException), .idExcCode(idExcCode),
		.opcode(opcode), .rs(rs), .rt(rt), .rd(idRd), .shamt(), .funct(),
		.imm16(imm16), .target26(target26)
	);

	executeStageReg execute_i (
		.clk(clk), .rst(rst), .wr(exWr), .flush(exFlush),
		.idPc(idPc), .idException(idException), .idExcCode(idExcCode),
		.rt(rt), .rd(idRd), .regDstRd(regDstRd), .regWrite(regWrite),
		.memRead(memRead), .memWrite(memWrite),
		.exPc(exPc), .exException(exException), .exExcCode(exExcCode), .exDest(exDest),
		.exRegWrite(exRegWrite), .exMemRead(exMemRead), .exMemWrite(), .stall(exStall)
	);

	memAccessStageReg memAccess_i (
		.clk(clk), .rst(rst), .wr(mem1Wr), .flush(mem1Flush),
		.exPc(exPc), .exException(exException), .exExcCode(exExcCode), .exDest(exDest),
		.exRegWrite(exRegWrite), .exMemRead(exMemRead),
		.aluResult(aluResult), .overflow(overflow),
		.m1Pc(m1Pc), .m1Exception(m1Exception), .m1ExcCode(m1ExcCode), .m1Dest(m1Dest),
		.m1RegWrite(m1RegWrite), .m1MemRead(m1MemRead), .m1Result(m1Result)
	);

	memResponseStageReg memResponse_i (
		.clk(clk), .rst(rst), .wr(mem2Wr), .flush(mem2Flush),
		.m1Pc(m1Pc), .m1Exception(m1Exception), .m1ExcCode(m1ExcCode), .m1Dest(m1Dest),
		.m1RegWrite(m1RegWrite), .m1MemRead(m1MemRead), .m1Result(m1Result),
		.m2Pc(m2Pc), .m2Exception(m2Exception), .m2ExcCode(m2ExcCode), .m2Dest(m2Dest),
		.m2RegWrite(m2RegWrite), .m2MemRead(m2MemRead), .m2Result(m2Result)
	);

	writebackStageReg writeback_i (
		.clk(clk), .rst(rst), .wr(wbWr), .flush(wbFlush),
		.m2Pc(m2Pc), .m2Exception(m2Exception), .m2ExcCode(m2ExcCode), .m2Dest(m2Dest),
		.m2RegWrite(m2RegWrite), .m2MemRead(m2MemRead), .m2Result(m2Result),
		.loadData(loadData),
		.wbPc(wbPc), .wbException(wbException), .wbExcCode(wbExcCode), .wbDest(wbDest),
		.wbRegWrite(wbRegWrite), .wbResult(wbResult)
	);

endmodule

// File: pipelineRegsTb.sv
`timescale 1ns/100ps

module pipelineRegsTb;

	logic clk;
	logic rst;
	logic ifWr, ifFlush, idWr, idFlush, exWr, exFlush;
	logic mem1Wr, mem1Flush, mem2Wr, mem2Flush, wbWr, wbFlush;
	logic [31:0] nextPc;
	logic fetchException;
	logic [4:0] fetchExcCode;
	pipeRegPkg::instrWord instr;
	logic regDstRd, regWrite, memRead, memWrite;
	logic [31:0] aluResult;
	logic overflow;
	logic [31:0] loadData;
	logic [31:0] ifPc;
	logic ifStall;
	logic [5:0] opcode;
	logic [4:0] rs, rt;
	logic [15:0] imm16;
	logic [25:0] target26;
	logic [4:0] exDest;
	logic exStall;
	logic [31:0] wbPc;
	logic wbException;
	logic [4:0] wbExcCode;
	logic [4:0] wbDest;
	logic wbRegWrite;
	logic [31:0] wbResult;

	// one record per instruction slot, each field driven at its own stage
	bit [31:0] slotPc [0:511];
	bit slotFe [0:511];
	bit [4:0] slotFeCode [0:511];
	bit [31:0] slotInstr [0:511];
	bit slotRegDst [0:511];
	bit slotRegWrite [0:511];
	bit slotMemRead [0:511];
	bit slotMemWrite [0:511];
	bit [31:0] slotAlu [0:511];
	bit slotOv [0:511];
	bit [31:0] slotLoad [0:511];

	// slots below 8 stay zero and stand for what was driven during reset
	int cyc = 8;
	int cleanRun;
	bit [31:0] lcgState = 32'd71583;

	bit chkFront, chkEx, chkWb;
	bit [31:0] expIfPc, expInstr, expWbPc, expWbResult;
	bit [4:0] expExDest, expWbCode, expWbDest;
	bit expWbExc, expWbRegWrite;

	pipelineRegs dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic bit [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// rd for R-type, rt for the immediate forms
	function automatic bit [4:0] destOf(input int s);
		return slotRegDst[s] ? slotInstr[s][15:11] : slotInstr[s][20:16];
	endfunction

	task automatic reportFail(input string msg);
		$display("[FAIL] %0t ns: %s", $time, msg);
		$display("*** FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	task automatic stepCycle(input int kind, input bit holdIf, input bit holdEx,
			input bit flushIf, input bit flushEx);
		bit [31:0] r;
		int s;
		@(negedge clk);
		if (rst || !ifWr || !idWr || !exWr || !mem1Wr || !mem2Wr || !wbWr || ifFlush || idFlush
				|| exFlush || mem1Flush || mem2Flush || wbFlush)
			cleanRun = 0;
		else
			cleanRun++;
		// state left by the last edge, checked at the coming one
		s = cyc - 6;
		chkFront = cleanRun >= 1;
		chkEx = cleanRun >= 2;
		chkWb = cleanRun >= 6;
		expIfPc = slotPc[cyc - 1];
		expInstr = slotInstr[cyc - 2];
		expExDest = destOf(cyc - 3);
		expWbPc = slotPc[s];
		expWbExc = slotFe[s] || slotOv[s];
		expWbCode = slotFe[s] ? slotFeCode[s] : (slotOv[s] ? pipeRegPkg::excOverflow : 5'd0);
		expWbDest = destOf(s);
		expWbRegWrite = slotRegWrite[s] && !expWbExc;
		expWbResult = slotMemRead[s] ? slotLoad[s] : slotAlu[s];

		r = nextRand();
		slotPc[cyc] = {r[31:2], 2'b00};
		slotInstr[cyc] = nextRand();
		slotAlu[cyc] = nextRand();
		slotLoad[cyc] = nextRand();
		r = nextRand();
		slotFe[cyc] = r[31:28] == 4'd0;
		slotFeCode[cyc] = slotFe[cyc] ? (r[27:24] % 11) + 1 : 5'd0;
		slotOv[cyc] = r[23:21] == 3'd0;
		slotRegDst[cyc] = r[20];
		slotRegWrite[cyc] = r[19];
		slotMemRead[cyc] = r[18:17] == 2'd1;
		slotMemWrite[cyc] = r[18:17] == 2'd2;
		if (kind != 0) begin
			slotFe[cyc] = kind == 2;
			slotFeCode[cyc] = (kind == 2) ? 5'd4 : 5'd0;
			slotOv[cyc] = 1'b1;
			slotRegWrite[cyc] = 1'b1;
		end

		nextPc = slotPc[cyc];
		fetchException = slotFe[cyc];
		fetchExcCode = slotFeCode[cyc];
		instr = slotInstr[cyc - 1];
		regDstRd = slotRegDst[cyc - 2];
		regWrite = slotRegWrite[cyc - 2];
		memRead = slotMemRead[cyc - 2];
		memWrite = slotMemWrite[cyc - 2];
		aluResult = slotAlu[cyc - 3];
		overflow = slotOv[cyc - 3];
		loadData = slotLoad[cyc - 5];
		rst = 1'b0;
		ifWr = !holdIf;
		exWr = !holdEx;
		ifFlush = flushIf;
		exFlush = flushEx;
		cyc++;
	endtask

	task automatic awaitWriteback(input bit [31:0] pcVal);
		int i;
		for (i = 0; i < 20; i++) begin
			if (wbPc == pcVal)
				break;
			stepCycle(0, 0, 0, 0, 0);
		end
		if (wbPc != pcVal) begin
			$display("timeout: PC %h never reached the writeback stage", pcVal);
			$display("*** FAILED ***");
			$fatal(1, "writeback wait timed out");
		end
	endtask

	resetValues: assert property (@(posedge clk) rst |=> (ifPc == pipeRegPkg::fetchResetPc
		&& !ifStall && !exStall && !wbRegWrite))
		else reportFail("reset values wrong after reset");
	fetchPassThrough: assert property (@(posedge clk) chkFront |-> ifPc == expIfPc)
		else reportFail($sformatf("ifPc %h, expected %h", $sampled(ifPc), expIfPc));
	decodeFields: assert property (@(posedge clk) chkFront |-> (opcode == expInstr[31:26]
		&& rs == expInstr[25:21] && rt == expInstr[20:16] && imm16 == expInstr[15:0]
		&& target26 == expInstr[25:0]))
		else reportFail($sformatf("decoded fields do not match instr %h", expInstr));
	destSelect: assert property (@(posedge clk) chkEx |-> exDest == expExDest)
		else reportFail($sformatf("exDest %0d, expected %0d", $sampled(exDest), expExDest));
	writebackState: assert property (@(posedge clk) chkWb |->
		(wbPc == expWbPc && wbDest == expWbDest))
		else reportFail($sformatf("wbPc %h wbDest %0d, expected %h %0d",
			$sampled(wbPc), $sampled(wbDest), expWbPc, expWbDest));
	writebackException: assert property (@(posedge clk) chkWb |-> (wbException == expWbExc
		&& wbExcCode == expWbCode && wbRegWrite == expWbRegWrite))
		else reportFail($sformatf("exception %b code %0d regWrite %b, expected %b %0d %b",
			$sampled(wbException), $sampled(wbExcCode), $sampled(wbRegWrite),
			expWbExc, expWbCode, expWbRegWrite));
	writebackValue: assert property (@(posedge clk) chkWb |-> wbResult == expWbResult)
		else reportFail($sformatf("wbResult %h, expected %h", $sampled(wbResult), expWbResult));
	fetchStallHold: assert property (@(posedge clk) (!rst && !ifFlush && !ifWr) |=>
		(ifStall && ifPc == $past(ifPc)))
		else reportFail("fetch register did not hold while ifWr was low");
	fetchStallClear: assert property (@(posedge clk) (rst || ifFlush || ifWr) |=> !ifStall)
		else reportFail("ifStall high after a write or flush");
	fetchFlush: assert property (@(posedge clk) (ifFlush && !rst) |=>
		ifPc == pipeRegPkg::fetchResetPc)
		else reportFail($sformatf("ifPc %h after flush", $sampled(ifPc)));
	executeStallHold: assert property (@(posedge clk) (!rst && !exFlush && !exWr) |=>
		(exStall && exDest == $past(exDest)))
		else reportFail("execute register did not hold while exWr was low");
	executeStallClear: assert property (@(posedge clk) (rst || exFlush || exWr) |=> !exStall)
		else reportFail("exStall high after a write or flush");
	executeFlush: assert property (@(posedge clk) exFlush |=> (exDest == '0 && !exStall))
		else reportFail($sformatf("exDest %0d after flush", $sampled(exDest)));
	// the flushed slot drains through both memory stages into writeback
	bubbleAtWriteback: assert property (@(posedge clk) $past(exFlush, 4) |->
		(!wbRegWrite && wbDest == '0 && wbPc == '0))
		else reportFail("execute flush bubble did not reach writeback cleared");

	initial begin
		bit [31:0] pcMark;
		rst = 1'b1;
		{ifWr, idWr, exWr, mem1Wr, mem2Wr, wbWr} = 6'h3f;
		{ifFlush, idFlush, exFlush, mem1Flush, mem2Flush, wbFlush} = 6'h00;
		nextPc = '0;
		fetchException = 1'b0;
		fetchExcCode = '0;
		instr = '0;
		{regDstRd, regWrite, memRead, memWrite} = 4'h0;
		aluResult = '0;
		overflow = 1'b0;
		loadData = '0;
		repeat (2) @(posedge clk);
		repeat (60) stepCycle(0, 0, 0, 0, 0);
		repeat (3) stepCycle(0, 1, 0, 0, 0);
		repeat (10) stepCycle(0, 0, 0, 0, 0);
		repeat (3) stepCycle(0, 0, 1, 0, 0);
		repeat (10) stepCycle(0, 0, 0, 0, 0);
		stepCycle(0, 0, 0, 0, 1);
		repeat (10) stepCycle(0, 0, 0, 0, 0);
		stepCycle(0, 0, 0, 1, 0);
		repeat (10) stepCycle(0, 0, 0, 0, 0);
		// overflow alone, then overflow behind a fetch exception
		stepCycle(1, 0, 0, 0, 0);
		pcMark = slotPc[cyc - 1];
		awaitWriteback(pcMark);
		stepCycle(2, 0, 0, 0, 0);
		pcMark = slotPc[cyc - 1];
		awaitWriteback(pcMark);
		repeat (100) stepCycle(0, 0, 0, 0, 0);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// File: writebackStageReg.sv
`timescale 1ns/100ps

module writebackStageReg (
	input logic clk,
	input logic rst,
	input logic wr,
	input logic flush,
	input logic [pipeRegPkg::addrWidth-1:0] m2Pc,
	input logic m2Exception,
	input logic [pipeRegPkg::excCodeWidth-1:0] m2ExcCode,
	input logic [pipeRegPkg::regAddrWidth-1:0] m2Dest,
	input logic m2RegWrite,
	input logic m2MemRead,
	input logic [pipeRegPkg::dataWidth-1:0] m2Result,
	input logic [pipeRegPkg::dataWidth-1:0] loadData,
	output logic [pipeRegPkg::addrWidth-1:0] wbPc,
	output logic wbException,
	output logic [pipeRegPkg::excCodeWidth-1:0] wbExcCode,
	output logic [pipeRegPkg::regAddrWidth-1:0] wbDest,
	output logic wbRegWrite,
	output logic [pipeRegPkg::dataWidth-1:0] wbResult
);

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			wbPc <= '0;
			wbException <= 1'b0;
			wbExcCode <= '0;
			wbDest <= '0;
			wbRegWrite <= 1'b0;
			wbResult <= '0;
		end else if (wr) begin
			wbPc <= m2Pc;
			wbException <= m2Exception;
			wbExcCode <= m2ExcCode;
			wbDest <= m2Dest;
			// a faulting instruction must not touch the register file
			wbRegWrite <= m2RegWrite && !m2Exception;
			wbResult <= m2MemRead ? loadData : m2Result;
		end
	end

endmodule
